/* run.sh */
#!/usr/bin/env bash
# builds the datapath testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f \
        --top-module datapathTb -o datapathSim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/datapathSim; then
    echo "simulation failed"
    exit 1
fi

exit 0

/* source/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit import datapathPkg::*; (
    input  logic   Clock,
    input  logic   rst,
    input  logic   Yin,
    input  logic   Zin,
    input  logic   IncPC,
    input  aluOp_t opcode,
    dataBusIf.alu  bus
);

    word_t  y;
    dword_t z;
    word_t  operandB;
    dword_t result;
    logic   opValid;
    word_t  quotient;
    word_t  remainder;
    logic signed [2*WordWidth-1:0] product;

    assign operandB = bus.busData;

    always_comb begin
        product = $signed(y) * $signed(operandB);
    end

    // divide by zero gives all-ones and keeps the dividend.
    always_comb begin
        if (operandB == '0) begin
            quotient = '1;
            remainder = y;
        end else begin
            quotient = $signed(y) / $signed(operandB);
            remainder = $signed(y) % $signed(operandB);
        end
    end

    // neg and not act on the bus operand only.
    always_comb begin
        result = '0;
        opValid = 1'b1;
        case (opcode)
            AluAdd: result[WordWidth-1:0] = y + operandB;
            AluSub: result[WordWidth-1:0] = y - operandB;
            AluAnd: result[WordWidth-1:0] = y & operandB;
            AluOr:  result[WordWidth-1:0] = y | operandB;
            AluShr: result[WordWidth-1:0] = y >> operandB[4:0];
            AluShl: result[WordWidth-1:0] = y << operandB[4:0];
            AluNeg: result[WordWidth-1:0] = -operandB;
            AluNot: result[WordWidth-1:0] = ~operandB;
            AluMul: result = product;
            AluDiv: result = {remainder, quotient};
            default: opValid = 1'b0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            y <= '0;
            z <= '0;
        end else begin
            if (Yin) begin
                y <= operandB;
            end
            if (Zin) begin
                if (IncPC) begin
                    z <= {{WordWidth{1'b0}}, word_t'(operandB + 1'b1)};
                end else begin
                    z <= result;
                end
            end
        end
    end

    assign bus.zHighValue = z[2*WordWidth-1:WordWidth];
    assign bus.zLowValue = z[WordWidth-1:0];

    opcodeDefined: assert property (
        @(posedge Clock) disable iff (rst) (Zin && !IncPC) |-> opValid)
        else $error("aluUnit: undefined opcode %b while loading Z", opcode);

endmodule

/* source/busEncoder.sv */
`timescale 1ns/1ps

module busEncoder import datapathPkg::*; #(
    parameter int NumRegs = 16
) (
    input  logic      Clock,
    input  regMask_t  regOut,
    input  logic      PCout,
    input  logic      MDRout,
    input  logic      HIout,
    input  logic      LOout,
    input  logic      Zhighout,
    input  logic      Zlowout,
    dataBusIf.encoder bus
);

    logic       anyRegOut;
    logic [6:0] srcSelect;

    assign anyRegOut = |regOut[NumRegs-1:0];

    // bit 6 is the register file, then the special sources.
    assign srcSelect = {anyRegOut, PCout, MDRout, HIout, LOout, Zhighout, Zlowout};

    // zero when nothing drives.
    assign bus.busData = ({WordWidth{srcSelect[6]}} & bus.regValue)
                       | ({WordWidth{srcSelect[5]}} & bus.pcValue)
                       | ({WordWidth{srcSelect[4]}} & bus.mdrValue)
                       | ({WordWidth{srcSelect[3]}} & bus.hiValue)
                       | ({WordWidth{srcSelect[2]}} & bus.loValue)
                       | ({WordWidth{srcSelect[1]}} & bus.zHighValue)
                       | ({WordWidth{srcSelect[0]}} & bus.zLowValue);

    // counts each general register as its own source.
    singleBusDriver: assert property (
        @(posedge Clock) $onehot0({regOut[NumRegs-1:0], srcSelect[5:0]}))
        else $error("busEncoder: more than one source enabled onto the bus");

endmodule

/* source/dataBusIf.sv */
`timescale 1ns/1ps

interface dataBusIf import datapathPkg::*; ();

    word_t busData;
    word_t regValue;
    word_t pcValue;
    word_t mdrValue;
    word_t hiValue;
    word_t loValue;
    word_t zHighValue;
    word_t zLowValue;

    modport encoder (
        output busData,
        input  regValue,
        input  pcValue,
        input  mdrValue,
        input  hiValue,
        input  loValue,
        input  zHighValue,
        input  zLowValue
    );

    modport regs (
        output regValue,
        input  busData
    );

    modport special (
        output pcValue,
        output mdrValue,
        output hiValue,
        output loValue,
        input  busData
    );

    modport alu (
        output zHighValue,
        output zLowValue,
        input  busData
    );

endinterface

/* source/datapath.sv */
`timescale 1ns/1ps

module datapath import datapathPkg::*; #(
    parameter int NumRegs = 16
) (
    input  logic     Clock,
    input  logic     rst,
    input  word_t    Mdatain,
    input  logic     Read,
    input  logic     IncPC,
    input  regMask_t regIn,
    input  regMask_t regOut,
    input  logic     PCin,
    input  logic     IRin,
    input  logic     MARin,
    input  logic     MDRin,
    input  logic     HIin,
    input  logic     LOin,
    input  logic     Yin,
    input  logic     Zin,
    input  logic     PCout,
    input  logic     MDRout,
    input  logic     HIout,
    input  logic     LOout,
    input  logic     Zhighout,
    input  logic     Zlowout,
    input  aluOp_t   opcode,
    output word_t    busValue,
    output word_t    marValue,
    output word_t    irValue
);

    dataBusIf bus ();

    registerFile #(.NumRegs(NumRegs)) i_registerFile (
        .Clock  (Clock),
        .rst    (rst),
        .regIn  (regIn),
        .regOut (regOut),
        .bus    (bus.regs)
    );

    busEncoder #(.NumRegs(NumRegs)) i_busEncoder (
        .Clock    (Clock),
        .regOut   (regOut),
        .PCout    (PCout),
        .MDRout   (MDRout),
        .HIout    (HIout),
        .LOout    (LOout),
        .Zhighout (Zhighout),
        .Zlowout  (Zlowout),
        .bus      (bus.encoder)
    );

    aluUnit i_aluUnit (
        .Clock  (Clock),
        .rst    (rst),
        .Yin    (Yin),
        .Zin    (Zin),
        .IncPC  (IncPC),
        .opcode (opcode),
        .bus    (bus.alu)
    );

    specialRegisters i_specialRegisters (
        .Clock    (Clock),
        .rst      (rst),
        .Mdatain  (Mdatain),
        .Read     (Read),
        .PCin     (PCin),
        .IRin     (IRin),
        .MARin    (MARin),
        .MDRin    (MDRin),
        .HIin     (HIin),
        .LOin     (LOin),
        .marValue (marValue),
        .irValue  (irValue),
        .bus      (bus.special)
    );

    assign busValue = bus.busData;

endmodule

/* source/datapathPkg.sv */
package datapathPkg;

    localparam int WordWidth = 32;
    localparam int MaskWidth = 16;

    typedef logic [WordWidth-1:0] word_t;

    // z result, high word in the upper half.
    typedef logic [2*WordWidth-1:0] dword_t;

    // one bit per general register.
    typedef logic [MaskWidth-1:0] regMask_t;

    typedef enum logic [4:0] {
        AluAdd = 5'b00011,
        AluAnd = 5'b00100,
        AluOr  = 5'b00101,
        AluSub = 5'b00110,
        AluShr = 5'b00111,
        AluShl = 5'b01000,
        AluMul = 5'b01111,
        AluDiv = 5'b10000,
        AluNeg = 5'b10001,
        AluNot = 5'b10010
    } aluOp_t;

endpackage

/* source/registerFile.sv */
`timescale 1ns/1ps

module registerFile import datapathPkg::*; #(
    parameter int NumRegs = 16
) (
    input  logic     Clock,
    input  logic     rst,
    input  regMask_t regIn,
    input  regMask_t regOut,
    dataBusIf.regs   bus
);

    word_t regs [NumRegs];
    word_t selected;

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NumRegs; i++) begin
                if (regIn[i]) begin
                    regs[i] <= bus.busData;
                end
            end
        end
    end

    // and-or select, regOut is one-hot.
    always_comb begin
        selected = '0;
        for (int i = 0; i < NumRegs; i++) begin
            if (regOut[i]) begin
                selected = selected | regs[i];
            end
        end
    end

    assign bus.regValue = selected;

    regOutOneHot: assert property (@(posedge Clock) disable iff (rst) $onehot0(regOut))
        else $error("registerFile: more than one regOut bit set");

endmodule

/* source/specialRegisters.sv */
`timescale 1ns/1ps

module specialRegisters import datapathPkg::*; (
    input  logic      Clock,
    input  logic      rst,
    input  word_t     Mdatain,
    input  logic      Read,
    input  logic      PCin,
    input  logic      IRin,
    input  logic      MARin,
    input  logic      MDRin,
    input  logic      HIin,
    input  logic      LOin,
    output word_t     marValue,
    output word_t     irValue,
    dataBusIf.special bus
);

    word_t pc;
    word_t ir;
    word_t mar;
    word_t mdr;
    word_t hi;
    word_t lo;
    word_t mdrSource;

    // memory data only during a read.
    assign mdrSource = Read ? Mdatain : bus.busData;

    always_ff @(posedge Clock) begin
        if (rst) begin
            pc <= '0;
            ir <= '0;
            mar <= '0;
            mdr <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            if (PCin) begin
                pc <= bus.busData;
            end
            if (IRin) begin
                ir <= bus.busData;
            end
            if (MARin) begin
                mar <= bus.busData;
            end
            if (MDRin) begin
                mdr <= mdrSource;
            end
            if (HIin) begin
                hi <= bus.busData;
            end
            if (LOin) begin
                lo <= bus.busData;
            end
        end
    end

    assign bus.pcValue = pc;
    assign bus.mdrValue = mdr;
    assign bus.hiValue = hi;
    assign bus.loValue = lo;
    assign marValue = mar;
    assign irValue = ir;

endmodule

/* testbench/datapathModel.svh */
`ifndef DATAPATH_MODEL_SVH
`define DATAPATH_MODEL_SVH

typedef enum int {
    SrcNone,
    SrcReg,
    SrcPc,
    SrcMdr,
    SrcHi,
    SrcLo,
    SrcZhigh,
    SrcZlow
} source_t;

// in-enable bits, lowest is PCin.
localparam logic [7:0] ToPc  = 8'h01;
localparam logic [7:0] ToIr  = 8'h02;
localparam logic [7:0] ToMar = 8'h04;
localparam logic [7:0] ToMdr = 8'h08;
localparam logic [7:0] ToHi  = 8'h10;
localparam logic [7:0] ToLo  = 8'h20;
localparam logic [7:0] ToY   = 8'h40;
localparam logic [7:0] ToZ   = 8'h80;

word_t  modelRegs [16];
word_t  modelPc;
word_t  modelIr;
word_t  modelMar;
word_t  modelMdr;
word_t  modelHi;
word_t  modelLo;
word_t  modelY;
dword_t modelZ;

function automatic void modelReset();
    foreach (modelRegs[i]) begin
        modelRegs[i] = '0;
    end
    modelPc = '0;
    modelIr = '0;
    modelMar = '0;
    modelMdr = '0;
    modelHi = '0;
    modelLo = '0;
    modelY = '0;
    modelZ = '0;
endfunction

// y is the first operand, the bus the second.
function automatic dword_t aluRule(aluOp_t op, word_t a, word_t b);
    longint sa;
    longint sb;
    longint q;
    longint r;
    sa = int'(a);
    sb = int'(b);
    case (op)
        AluAdd: return {32'h0, a + b};
        AluSub: return {32'h0, a - b};
        AluAnd: return {32'h0, a & b};
        AluOr:  return {32'h0, a | b};
        AluShr: return {32'h0, a >> b[4:0]};
        AluShl: return {32'h0, a << b[4:0]};
        AluNeg: return {32'h0, word_t'(0) - b};
        AluNot: return {32'h0, ~b};
        AluMul: return dword_t'(sa * sb);
        AluDiv: begin
            if (b == '0) begin
                return {a, 32'hffff_ffff};
            end
            q = sa / sb;
            r = sa % sb;
            return {r[31:0], q[31:0]};
        end
        default: return '0;
    endcase
endfunction

function automatic word_t modelBus(source_t src, int idx);
    case (src)
        SrcReg:   return modelRegs[idx];
        SrcPc:    return modelPc;
        SrcMdr:   return modelMdr;
        SrcHi:    return modelHi;
        SrcLo:    return modelLo;
        SrcZhigh: return modelZ[63:32];
        SrcZlow:  return modelZ[31:0];
        default:  return '0;
    endcase
endfunction

// one clock edge of register loads.
function automatic void modelUpdate(logic [7:0] dst, int dstIdx, word_t bus, aluOp_t op,
                                    logic incPc, logic read, word_t memData);
    if ((dst & ToZ) != 0) begin
        modelZ = incPc ? {32'h0, bus + 32'd1} : aluRule(op, modelY, bus);
    end
    if ((dst & ToY) != 0) modelY = bus;
    if ((dst & ToPc) != 0) modelPc = bus;
    if ((dst & ToIr) != 0) modelIr = bus;
    if ((dst & ToMar) != 0) modelMar = bus;
    if ((dst & ToMdr) != 0) modelMdr = read ? memData : bus;
    if ((dst & ToHi) != 0) modelHi = bus;
    if ((dst & ToLo) != 0) modelLo = bus;
    if (dstIdx >= 0) modelRegs[dstIdx] = bus;
endfunction

`endif

/* testbench/datapathTb.sv */
`timescale 1ns/1ps

module datapathTb import datapathPkg::*; ;

    localparam int NumRounds = 60;
    localparam int StepsPerRound = 20;
    localparam int TotalSteps = 16 + NumRounds * StepsPerRound;

    logic     Clock;
    logic     rst;
    word_t    Mdatain;
    logic     Read;
    logic     IncPC;
    regMask_t regIn;
    regMask_t regOut;
    logic     PCin;
    logic     IRin;
    logic     MARin;
    logic     MDRin;
    logic     HIin;
    logic     LOin;
    logic     Yin;
    logic     Zin;
    logic     PCout;
    logic     MDRout;
    logic     HIout;
    logic     LOout;
    logic     Zhighout;
    logic     Zlowout;
    aluOp_t   opcode;
    word_t    busValue;
    word_t    marValue;
    word_t    irValue;

    aluOp_t aluOps [10] = '{AluAdd, AluAnd, AluOr, AluSub, AluShr,
                            AluShl, AluMul, AluDiv, AluNeg, AluNot};

    `include "datapathModel.svh"

    datapath i_datapath (.*);

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    initial begin
        #(TotalSteps * 10 + 200);
        $display("TEST FAIL");
        $display("Watchdog timeout, the test sequence did not finish in time");
        $fatal(1);
    end

    task automatic checkWord(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("TEST FAIL");
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
            $fatal(1);
        end
    endtask

    task automatic checkState(input int idx, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("TEST FAIL");
            $display("Mismatch busValue (r%0d): got %h, expected %h", idx, actual, expected);
            $fatal(1);
        end
    endtask

    task automatic clearControls();
        {Zin, Yin, LOin, HIin, MDRin, MARin, IRin, PCin} = '0;
        {PCout, MDRout, HIout, LOout, Zhighout, Zlowout} = '0;
        regIn = '0;
        regOut = '0;
        Read = 1'b0;
        IncPC = 1'b0;
        Mdatain = '0;
        opcode = AluAdd;
    endtask

    // one bus transfer driven 1 ns after the edge.
    task automatic transfer(input source_t src, input int srcIdx, input logic [7:0] dst,
                            input int dstIdx, input aluOp_t op, input logic incPc,
                            input logic read, input word_t memData);
        word_t expBus;
        clearControls();
        {Zin, Yin, LOin, HIin, MDRin, MARin, IRin, PCin} = dst;
        if (dstIdx >= 0) regIn = regMask_t'(1) << dstIdx;
        if (src == SrcReg) regOut = regMask_t'(1) << srcIdx;
        PCout = (src == SrcPc);
        MDRout = (src == SrcMdr);
        HIout = (src == SrcHi);
        LOout = (src == SrcLo);
        Zhighout = (src == SrcZhigh);
        Zlowout = (src == SrcZlow);
        opcode = op;
        IncPC = incPc;
        Read = read;
        Mdatain = memData;
        expBus = modelBus(src, srcIdx);
        #1;
        if (src == SrcReg) checkState(srcIdx, busValue, expBus);
        else checkWord("busValue", busValue, expBus);
        @(posedge Clock);
        modelUpdate(dst, dstIdx, expBus, op, incPc, read, memData);
        #1;
        checkWord("marValue", marValue, modelMar);
        checkWord("irValue", irValue, modelIr);
    endtask

    task automatic move(input source_t src, input int srcIdx, input logic [7:0] dst,
                        input int dstIdx);
        transfer(src, srcIdx, dst, dstIdx, AluAdd, 1'b0, 1'b0, '0);
    endtask

    initial begin
        word_t  valA;
        word_t  valB;
        int     regA;
        int     regB;
        aluOp_t op;
        void'($urandom(53266));
        clearControls();
        rst = 1'b1;
        modelReset();
        repeat (16) @(posedge Clock);
        #1;
        rst = 1'b0;
        checkWord("busValue", busValue, '0);
        checkWord("marValue", marValue, '0);
        checkWord("irValue", irValue, '0);

        for (int round = 0; round < NumRounds; round++) begin
            regA = $urandom_range(0, 15);
            regB = (regA + $urandom_range(1, 15)) % 16;
            op = aluOps[$urandom_range(0, 9)];
            valA = $urandom();
            valB = $urandom();
            if (op == AluDiv && $urandom_range(0, 1) == 0) valB = '0;

            // operands through memory data into two registers.
            transfer(SrcNone, 0, ToMdr, -1, AluAdd, 1'b0, 1'b1, valA);
            move(SrcMdr, 0, '0, regA);
            move(SrcReg, regA, '0, -1);
            transfer(SrcNone, 0, ToMdr, -1, AluAdd, 1'b0, 1'b1, valB);
            move(SrcMdr, 0, '0, regB);
            move(SrcReg, regB, '0, -1);

            move(SrcReg, regA, ToY, -1);
            transfer(SrcReg, regB, ToZ, -1, op, 1'b0, 1'b0, '0);
            move(SrcZlow, 0, ToLo, -1);
            move(SrcZhigh, 0, ToHi, -1);
            move(SrcLo, 0, '0, -1);
            move(SrcHi, 0, '0, -1);

            // pc increment through Z.
            transfer(SrcPc, 0, ToMar | ToZ, -1, AluAdd, 1'b1, 1'b0, '0);
            move(SrcZlow, 0, ToPc, -1);
            move(SrcPc, 0, '0, -1);

            transfer(SrcNone, 0, ToMdr, -1, AluAdd, 1'b0, 1'b1, $urandom());
            move(SrcMdr, 0, ToIr, -1);

            // mdr from the bus while memory data carries another value.
            transfer(SrcReg, regA, ToMdr, -1, AluAdd, 1'b0, 1'b0, $urandom());
            move(SrcMdr, 0, '0, -1);

            move(SrcNone, 0, '0, -1);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+testbench
source/datapathPkg.sv
source/dataBusIf.sv
source/registerFile.sv
source/busEncoder.sv
source/aluUnit.sv
source/specialRegisters.sv
source/datapath.sv
testbench/datapathTb.sv
